// File: common/vga_bus_pkg.sv
package vga_bus_pkg;

    // ==================================================================
    // Core-side address map
    // ==================================================================
    localparam logic [15:0] REG_CTL   = 16'h0000;
    localparam logic [15:0] REG_CRX   = 16'h0001;
    localparam logic [15:0] REG_CRY   = 16'h0002;

    // Text buffer, one byte per cell, row major
    localparam logic [15:0] TEXT_BASE = 16'h1000;
    localparam int          TEXT_SIZE = 3200;

    // Glyph table, 12 bytes per character
    localparam logic [15:0] FONT_BASE = 16'h2000;
    localparam int          FONT_SIZE = 3072;

    // ==================================================================
    // Bus and RAM port payloads
    // ==================================================================
    typedef struct packed {
        logic        we;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } vga_bus_req_t;

    // Address is an offset inside the selected RAM
    typedef struct packed {
        logic        en;
        logic        we;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } ram_port_t;

endpackage

// File: common/vga_video_pkg.sv
package vga_video_pkg;

    // ==================================================================
    // 640x480 timing, in pixel clocks and lines
    // ==================================================================
    localparam int H_VISIBLE = 640;
    localparam int H_FRONT   = 16;
    localparam int H_SYNC    = 96;
    localparam int H_TOTAL   = 800;

    localparam int V_VISIBLE = 480;
    localparam int V_FRONT   = 10;
    localparam int V_SYNC    = 2;
    localparam int V_TOTAL   = 525;

    // Text grid and glyph cell
    localparam int COLS    = 80;
    localparam int ROWS    = 40;
    localparam int GLYPH_W = 8;
    localparam int GLYPH_H = 12;

    // Colours are {r, g, b}
    typedef struct packed {
        logic       enable;
        logic       cursor_en;
        logic [2:0] fg;
        logic [2:0] bg;
    } vga_ctl_t;

    // Display on, cursor on, white on black
    localparam vga_ctl_t CTL_RESET = 8'hF8;

    typedef struct packed {
        logic r;
        logic g;
        logic b;
        logic hsync;
        logic vsync;
    } vga_pixel_t;

endpackage

// File: hdl/dual_clock_ram.sv
`timescale 1ns/100ps

module dual_clock_ram
    import vga_bus_pkg::*;
#(
    parameter int DEPTH = 3200
) (
    input  logic        clk_vga,
    input  logic        clk_core,
    input  logic [15:0] addr_a,
    input  ram_port_t   port_b,
    output logic [7:0]  data_a,
    output logic [7:0]  data_b
);

    localparam int AW = $clog2(DEPTH);

    logic [7:0] mem [DEPTH];
    logic       in_a;
    logic       in_b;

    assign in_a = addr_a < DEPTH;
    assign in_b = port_b.addr < DEPTH;

    // Video side, read only
    always_ff @(posedge clk_vga) begin
        data_a <= in_a ? mem[addr_a[AW-1:0]] : '0;
    end

    // Core side, read before write
    always_ff @(posedge clk_core) begin
        if (port_b.en) begin
            if (port_b.we && in_b) begin
                mem[port_b.addr[AW-1:0]] <= port_b.wdata;
            end
            data_b <= in_b ? mem[port_b.addr[AW-1:0]] : '0;
        end
    end

endmodule

// File: hdl/vga_mmio_regs.sv
`timescale 1ns/100ps

module vga_mmio_regs
    import vga_bus_pkg::*, vga_video_pkg::*;
(
    input  logic         clk_core,
    input  logic         rst_n,
    input  logic         req,
    input  vga_bus_req_t bus_req,
    input  logic [7:0]   text_rdata,
    input  logic [7:0]   font_rdata,
    output logic         ack,
    output logic [7:0]   rdata,
    output vga_ctl_t     ctl,
    output logic [7:0]   crx,
    output logic [7:0]   cry,
    output ram_port_t    text_port,
    output ram_port_t    font_port
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_CAPT,
        ST_ACK
    } state_t;

    state_t      state;
    logic        hit_text;
    logic        hit_font;
    logic [15:0] text_off;
    logic [15:0] font_off;
    logic [7:0]  rd_mux;

    // ==================================================================
    // Address decode
    // ==================================================================
    assign text_off = bus_req.addr - TEXT_BASE;
    assign font_off = bus_req.addr - FONT_BASE;
    assign hit_text = (bus_req.addr >= TEXT_BASE) && (text_off < TEXT_SIZE);
    assign hit_font = (bus_req.addr >= FONT_BASE) && (font_off < FONT_SIZE);

    // One-cycle RAM strobe in the first cycle after req is taken
    assign text_port = '{en: (state == ST_ISSUE) && hit_text, we: bus_req.we,
                         addr: text_off, wdata: bus_req.wdata};
    assign font_port = '{en: (state == ST_ISSUE) && hit_font, we: bus_req.we,
                         addr: font_off, wdata: bus_req.wdata};

    always_comb begin
        if (hit_text) begin
            rd_mux = text_rdata;
        end else if (hit_font) begin
            rd_mux = font_rdata;
        end else if (bus_req.addr == REG_CTL) begin
            rd_mux = ctl;
        end else if (bus_req.addr == REG_CRX) begin
            rd_mux = crx;
        end else if (bus_req.addr == REG_CRY) begin
            rd_mux = cry;
        end else begin
            rd_mux = '0;
        end
    end

    // ==================================================================
    // Four-phase handshake and registers
    // ==================================================================
    always_ff @(posedge clk_core) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            ack   <= 1'b0;
            rdata <= '0;
            ctl   <= CTL_RESET;
            crx   <= '0;
            cry   <= '0;
        end else begin
            unique case (state)
                ST_IDLE: begin
                    if (req) begin
                        state <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (bus_req.we) begin
                        if (bus_req.addr == REG_CTL) ctl <= bus_req.wdata;
                        if (bus_req.addr == REG_CRX) crx <= bus_req.wdata;
                        if (bus_req.addr == REG_CRY) cry <= bus_req.wdata;
                    end
                    state <= ST_CAPT;
                end
                ST_CAPT: begin
                    // RAM data is valid now
                    rdata <= rd_mux;
                    ack   <= 1'b1;
                    state <= ST_ACK;
                end
                ST_ACK: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: vga80x40/vga80x40.sv
`timescale 1ns/100ps

module vga80x40
    import vga_video_pkg::*;
(
    input  logic        clk_vga,
    input  logic        rst_n,
    input  vga_ctl_t    ctl,
    input  logic [7:0]  crx,
    input  logic [7:0]  cry,
    input  logic [7:0]  text_data,
    input  logic [7:0]  font_data,
    output logic [15:0] text_addr,
    output logic [15:0] font_addr,
    output vga_pixel_t  pixel
);

    typedef struct packed {
        vga_ctl_t   ctl;
        logic [7:0] crx;
        logic [7:0] cry;
    } cfg_t;

    // Per-pixel state travelling with the fetch
    typedef struct packed {
        logic       vis;
        logic       cur;
        logic [2:0] px;
        logic [3:0] line;
        logic       hs_on;
        logic       vs_on;
    } pipe_t;

    logic [1:0] rst_sync;
    logic       rst_vga_n;
    cfg_t       cfg_s1;
    cfg_t       cfg_s2;
    cfg_t       cfg;
    logic [9:0] h;
    logic [9:0] v;
    logic [3:0] line;
    logic [5:0] row;
    logic [6:0] col;
    logic [2:0] px;
    logic       h_end;
    logic       v_end;
    pipe_t      pipe_0;
    pipe_t      pipe_1;
    pipe_t      pipe_2;
    logic       bit_on;
    logic [2:0] rgb;

    // ==================================================================
    // Reset and control crossing
    // ==================================================================
    always_ff @(posedge clk_vga) begin
        rst_sync <= {rst_sync[0], rst_n};
    end
    assign rst_vga_n = rst_sync[1];

    // Latched once per frame
    always_ff @(posedge clk_vga) begin
        if (!rst_vga_n) begin
            cfg_s1 <= '0;
            cfg_s2 <= '0;
            cfg    <= '0;
        end else begin
            cfg_s1 <= '{ctl: ctl, crx: crx, cry: cry};
            cfg_s2 <= cfg_s1;
            if (h_end && v_end) cfg <= cfg_s2;
        end
    end

    // ==================================================================
    // Timing counters
    // ==================================================================
    assign h_end = (h == 10'(H_TOTAL - 1));
    assign v_end = (v == 10'(V_TOTAL - 1));

    always_ff @(posedge clk_vga) begin
        if (!rst_vga_n) begin
            h    <= '0;
            v    <= '0;
            line <= '0;
            row  <= '0;
        end else if (!h_end) begin
            h <= h + 10'd1;
        end else begin
            h <= '0;
            if (v_end) begin
                v    <= '0;
                line <= '0;
                row  <= '0;
            end else begin
                v <= v + 10'd1;
                if (line == 4'(GLYPH_H - 1)) begin
                    line <= '0;
                    row  <= row + 6'd1;
                end else begin
                    line <= line + 4'd1;
                end
            end
        end
    end

    assign col = 7'(h / GLYPH_W);
    assign px  = 3'(h % GLYPH_W);

    // ==================================================================
    // Fetch pipeline
    // ==================================================================
    always_comb begin
        pipe_0.vis   = (col < COLS) && (row < ROWS);
        pipe_0.cur   = cfg.ctl.cursor_en && ({1'b0, col} == cfg.crx)
                       && ({2'b00, row} == cfg.cry);
        pipe_0.px    = px;
        pipe_0.line  = line;
        pipe_0.hs_on = (h >= H_VISIBLE + H_FRONT) && (h < H_VISIBLE + H_FRONT + H_SYNC);
        pipe_0.vs_on = (v >= V_VISIBLE + V_FRONT) && (v < V_VISIBLE + V_FRONT + V_SYNC);
    end

    assign text_addr = 16'(row * COLS + col);
    assign font_addr = 16'(text_data * GLYPH_H + pipe_1.line);

    always_ff @(posedge clk_vga) begin
        if (!rst_vga_n) begin
            pipe_1 <= '0;
            pipe_2 <= '0;
        end else begin
            pipe_1 <= pipe_0;
            pipe_2 <= pipe_1;
        end
    end

    // MSB is the leftmost pixel
    assign bit_on = font_data[3'd7 - pipe_2.px];

    always_comb begin
        if (!pipe_2.vis || !cfg.ctl.enable) begin
            rgb = '0;
        end else if (bit_on ^ pipe_2.cur) begin
            rgb = cfg.ctl.fg;
        end else begin
            rgb = cfg.ctl.bg;
        end
    end

    always_ff @(posedge clk_vga) begin
        if (!rst_vga_n) begin
            pixel <= '{r: 1'b0, g: 1'b0, b: 1'b0, hsync: 1'b1, vsync: 1'b1};
        end else begin
            pixel <= '{r: rgb[2], g: rgb[1], b: rgb[0],
                       hsync: !pipe_2.hs_on, vsync: !pipe_2.vs_on};
        end
    end

endmodule

// File: hdl/vga_text_top.sv
`timescale 1ns/100ps

module vga_text_top
    import vga_bus_pkg::*, vga_video_pkg::*;
(
    input  logic         clk_core,
    input  logic         clk_vga,
    input  logic         rst_n,
    input  logic         req,
    input  vga_bus_req_t bus_req,
    output logic         ack,
    output logic [7:0]   rdata,
    output logic [2:0]   vga_red,
    output logic [2:0]   vga_green,
    output logic [1:0]   vga_blue,
    output logic         hsync,
    output logic         vsync
);

    vga_ctl_t    ctl;
    logic [7:0]  crx;
    logic [7:0]  cry;
    ram_port_t   text_port;
    ram_port_t   font_port;
    logic [7:0]  text_rdata;
    logic [7:0]  font_rdata;
    logic [15:0] text_addr;
    logic [15:0] font_addr;
    logic [7:0]  text_data;
    logic [7:0]  font_data;
    vga_pixel_t  pixel;

    // ==================================================================
    // Core side
    // ==================================================================
    vga_mmio_regs i_regs (
        .clk_core   (clk_core),
        .rst_n      (rst_n),
        .req        (req),
        .bus_req    (bus_req),
        .text_rdata (text_rdata),
        .font_rdata (font_rdata),
        .ack        (ack),
        .rdata      (rdata),
        .ctl        (ctl),
        .crx        (crx),
        .cry        (cry),
        .text_port  (text_port),
        .font_port  (font_port)
    );

    dual_clock_ram #(.DEPTH(TEXT_SIZE)) text_ram (
        .clk_vga  (clk_vga),
        .clk_core (clk_core),
        .addr_a   (text_addr),
        .port_b   (text_port),
        .data_a   (text_data),
        .data_b   (text_rdata)
    );

    dual_clock_ram #(.DEPTH(FONT_SIZE)) font_ram (
        .clk_vga  (clk_vga),
        .clk_core (clk_core),
        .addr_a   (font_addr),
        .port_b   (font_port),
        .data_a   (font_data),
        .data_b   (font_rdata)
    );

    // ==================================================================
    // Video side
    // ==================================================================
    vga80x40 i_vga (
        .clk_vga   (clk_vga),
        .rst_n     (rst_n),
        .ctl       (ctl),
        .crx       (crx),
        .cry       (cry),
        .text_data (text_data),
        .font_data (font_data),
        .text_addr (text_addr),
        .font_addr (font_addr),
        .pixel     (pixel)
    );

    // One bit per colour fanned out to the DAC pins
    assign vga_red   = {3{pixel.r}};
    assign vga_green = {3{pixel.g}};
    assign vga_blue  = {2{pixel.b}};
    assign hsync     = pixel.hsync;
    assign vsync     = pixel.vsync;

endmodule

// File: bench/vga_text_assertions.sv
`timescale 1ns/100ps

module vga_text_assertions
    import vga_bus_pkg::*;
(
    input logic         clk,
    input logic         rst_n,
    input logic         req,
    input logic         ack,
    input vga_bus_req_t bus_req,
    input logic         hsync,
    input logic         vsync,
    input logic [2:0]   rgb
);

    int fails = 0;

    // ==================================================================
    // Four-phase handshake
    // ==================================================================
    ack_rise_with_req: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(ack) |-> $past(req)
    ) else begin
        fails++;
        $error("ack rose while req was low");
    end

    ack_fall_after_req: assert property (
        @(posedge clk) disable iff (!rst_n) $fell(ack) |-> !$past(req)
    ) else begin
        fails++;
        $error("ack fell while req was still high");
    end

    // Master holds the request until ack
    req_stable: assert property (
        @(posedge clk) disable iff (!rst_n) (req && !ack) |=> $stable(bus_req)
    ) else begin
        fails++;
        $error("bus_req changed before ack");
    end

    // No colour while either sync pulse is active
    blank_in_sync: assert property (
        @(posedge clk) disable iff (!rst_n) (!hsync || !vsync) |-> (rgb == 3'b000)
    ) else begin
        fails++;
        $error("colour not zero during a sync pulse");
    end

endmodule

// File: bench/tb_vga_text.sv
`timescale 1ns/100ps

module tb_vga_text
    import vga_bus_pkg::*;
();

    typedef struct packed {
        logic [7:0]  op;
        logic [15:0] a;
        logic [15:0] b;
        logic [7:0]  c;
    } case_t;

    logic         clk_core = 1'b0;
    logic         clk_vga = 1'b0;
    logic         rst_n;
    logic         req;
    vga_bus_req_t bus_req;
    logic         ack;
    logic [7:0]   rdata;
    logic [2:0]   vga_red;
    logic [2:0]   vga_green;
    logic [1:0]   vga_blue;
    logic         hsync;
    logic         vsync;

    case_t        cases[$];
    int           value_errors = 0;
    int           other_errors = 0;
    int           vga_cycles = 0;
    int           frame_ref = 0;
    logic         frame_seen = 1'b0;
    logic         mon_on = 1'b0;
    real          limit_ns = 0.0;
    logic         hs_prev;
    logic         vs_prev;
    int           hs_cnt = 0;
    int           hs_low = 0;
    int           vs_cnt = 0;
    int           vs_low = 0;
    int           vs_periods = 0;

    always #5 clk_core = ~clk_core;
    always #20 clk_vga = ~clk_vga;

    always @(posedge clk_vga) begin
        vga_cycles <= vga_cycles + 1;
    end

    vga_text_top i_vga_text_top (
        .clk_core  (clk_core),
        .clk_vga   (clk_vga),
        .rst_n     (rst_n),
        .req       (req),
        .bus_req   (bus_req),
        .ack       (ack),
        .rdata     (rdata),
        .vga_red   (vga_red),
        .vga_green (vga_green),
        .vga_blue  (vga_blue),
        .hsync     (hsync),
        .vsync     (vsync)
    );

    bind vga_mmio_regs vga_text_assertions i_bus_checks (
        .clk     (clk_core),
        .rst_n   (rst_n),
        .req     (req),
        .ack     (ack),
        .bus_req (bus_req),
        .hsync   (1'b1),
        .vsync   (1'b1),
        .rgb     (3'b000)
    );

    bind vga80x40 vga_text_assertions i_video_checks (
        .clk     (clk_vga),
        .rst_n   (rst_vga_n),
        .req     (1'b0),
        .ack     (1'b0),
        .bus_req ('0),
        .hsync   (pixel.hsync),
        .vsync   (pixel.vsync),
        .rgb     ({pixel.r, pixel.g, pixel.b})
    );

    // ==================================================================
    // Helpers
    // ==================================================================
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            value_errors++;
            $display("ERROR t=%0t %s: expected 0x%0h, got 0x%0h", $time, name, expected, actual);
        end
    endtask

    task automatic bus_transfer(input logic we, input logic [15:0] addr,
                                input logic [7:0] wdata, output logic [7:0] data);
        int cycles;
        @(negedge clk_core);
        bus_req = '{we: we, addr: addr, wdata: wdata};
        req     = 1'b1;
        cycles  = 0;
        while (ack !== 1'b1 && cycles < 16) begin
            @(negedge clk_core);
            cycles++;
        end
        data = rdata;
        if (ack !== 1'b1) begin
            other_errors++;
            $display("Bus access to 0x%04h was never acknowledged", addr);
        end
        req    = 1'b0;
        cycles = 0;
        while (ack !== 1'b0 && cycles < 16) begin
            @(negedge clk_core);
            cycles++;
        end
        if (ack !== 1'b0) begin
            other_errors++;
            $display("ack stayed high after req was dropped at 0x%04h", addr);
        end
    endtask

    task automatic wait_frame();
        @(negedge vsync);
        @(negedge clk_vga);
        frame_ref  = vga_cycles;
        frame_seen = 1'b1;
    endtask

    // Pixel (x, y) leaves the DUT 28000 + 800*y + x cycles after vsync falls
    task automatic check_pixel(input int x, input int y, input logic [2:0] rgb);
        int         target;
        logic [7:0] expected;
        target   = frame_ref + 28000 + 800 * y + x;
        expected = {{3{rgb[2]}}, {3{rgb[1]}}, {2{rgb[0]}}};
        @(negedge clk_vga);
        if (!frame_seen || vga_cycles > target) begin
            other_errors++;
            $display("Pixel (%0d, %0d) cannot be sampled, no frame start or already past",
                     x, y);
        end else begin
            while (vga_cycles < target) begin
                @(negedge clk_vga);
            end
            check_value($sformatf("pixel(%0d,%0d)", x, y), expected,
                        {vga_red, vga_green, vga_blue});
        end
    endtask

    // Sync widths and periods measured from fall to fall
    always @(negedge clk_vga) begin
        if (mon_on && hs_prev === 1'b1 && hsync === 1'b0) begin
            if (hs_cnt > 0) begin
                check_value("hsync period", 800, hs_cnt);
                check_value("hsync low", 96, hs_low);
            end
            hs_cnt = 1;
            hs_low = 1;
        end else if (hs_cnt > 0) begin
            hs_cnt++;
            hs_low += (hsync === 1'b0);
        end
        if (mon_on && vs_prev === 1'b1 && vsync === 1'b0) begin
            if (vs_cnt > 0) begin
                check_value("vsync period", 420000, vs_cnt);
                check_value("vsync low", 1600, vs_low);
                vs_periods++;
            end
            vs_cnt = 1;
            vs_low = 1;
        end else if (vs_cnt > 0) begin
            vs_cnt++;
            vs_low += (vsync === 1'b0);
        end
        hs_prev = hsync;
        vs_prev = vsync;
    end

    initial begin
        wait (limit_ns > 0.0);
        #(limit_ns);
        $display("Watchdog expired at %0t before all cases ran", $time);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial begin
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [15:0] a;
        logic [15:0] b;
        logic [7:0]  c;
        logic [7:0]  data;
        int          frames;
        int          bus_lines;
        int          assert_fails;

        rst_n     = 1'b0;
        req       = 1'b0;
        bus_req   = '0;
        frames    = 0;
        bus_lines = 0;

        fd = $fopen("bench/vga_text_cases.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Cannot open bench/vga_text_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line[0] != "#" && line[0] != "\n") begin
                    a = '0;
                    b = '0;
                    c = '0;
                    n = $sscanf(line, "%c", op);
                    if (op == "P") begin
                        n = $sscanf(line, "%c %d %d %h", op, a, b, c);
                    end else begin
                        n = $sscanf(line, "%c %h %h", op, a, b);
                    end
                    if (op == "F") frames++;
                    if (op == "W" || op == "R") bus_lines++;
                    cases.push_back('{op: op, a: a, b: b, c: c});
                end
            end
            $fclose(fd);
        end

        // One frame is 420000 pixel clocks of 40 ns
        limit_ns = (frames + 1) * 16.8e6 + bus_lines * 1.0e3;

        repeat (4) @(posedge clk_vga);
        @(posedge clk_core);
        @(negedge clk_core);
        rst_n = 1'b1;
        repeat (4) @(negedge clk_vga);
        mon_on = 1'b1;

        foreach (cases[i]) begin
            case (cases[i].op)
                "W": bus_transfer(1'b1, cases[i].a, cases[i].b[7:0], data);
                "R": begin
                    bus_transfer(1'b0, cases[i].a, 8'h00, data);
                    check_value($sformatf("rdata@0x%04h", cases[i].a), cases[i].b, data);
                end
                "F": wait_frame();
                "P": check_pixel(cases[i].a, cases[i].b, cases[i].c[2:0]);
                default: begin
                    other_errors++;
                    $display("Unknown case operation '%c'", cases[i].op);
                end
            endcase
        end

        if (vs_periods == 0) begin
            other_errors++;
            $display("No full vsync period was observed");
        end

        assert_fails = i_vga_text_top.i_regs.i_bus_checks.fails
                       + i_vga_text_top.i_vga.i_video_checks.fails;
        $display("Value errors: %0d, other failures: %0d, assertion failures: %0d",
                 value_errors, other_errors, assert_fails);
        if (value_errors == 0 && other_errors == 0 && assert_fails == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: vga_text.f
common/vga_bus_pkg.sv
common/vga_video_pkg.sv
hdl/dual_clock_ram.sv
hdl/vga_mmio_regs.sv
vga80x40/vga80x40.sv
hdl/vga_text_top.sv
bench/vga_text_assertions.sv
bench/tb_vga_text.sv

// File: Bender.yml
package:
  name: vga_text

sources:
  # Packages first, then the RTL in dependency order
  - common/vga_bus_pkg.sv
  - common/vga_video_pkg.sv
  - hdl/dual_clock_ram.sv
  - hdl/vga_mmio_regs.sv
  - vga80x40/vga80x40.sv
  - hdl/vga_text_top.sv

  - target: test
    files:
      - bench/vga_text_assertions.sv
      - bench/tb_vga_text.sv

// File: bench/vga_text_cases.txt
# W addr data | R addr expected : bus write or read, hex values
# F : wait for vsync fall | P x y rgb : pixel in the following frame, x y decimal, rgb hex
R 0000 F8
R 0001 00
R 0002 00
W 0000 F1
W 0001 03
W 0002 01
R 0000 F1
R 0001 03
R 0002 01
W 1000 11
W 1640 22
W 1C7F 33
W 2000 44
W 2600 55
W 2BFF 66
R 1000 11
R 1640 22
R 1C7F 33
R 2000 44
R 2600 55
R 2BFF 66
W 0010 5A
R 0010 00
W 1C80 77
R 1C80 00
W 230C 81
W 2311 3C
W 1052 41
W 1053 41
F
P 16 12 6
P 17 12 1
P 23 12 6
P 24 12 1
P 25 12 6
P 18 17 6
P 26 17 1
W 0000 71
R 0000 71
F
P 16 12 0
P 24 12 0
P 18 17 0
